//--- deck_pkg.sv
package deck_pkg;

	localparam int SAMPLE_W = 16;
	localparam int MAX_FACTOR = 8; // Largest rate factor

	typedef enum logic [2:0] {
		IDLE = 3'd0,
		PLAY = 3'd1,
		REC = 3'd2,
		REC_PAUSE = 3'd3,
		PLAY_PAUSE = 3'd4
	} deck_state_t;

	// Factor holds N-1
	typedef struct packed {
		logic slow;
		logic [2:0] factor;
	} rate_t;

	localparam rate_t RATE_X1 = '{slow: 1'b0, factor: 3'd0};

	// Single-cycle key pulses
	typedef struct packed {
		logic play;
		logic rec;
		logic stop;
		logic faster;
		logic slower;
	} deck_cmd_t;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	typedef struct packed {
		deck_state_t state;
		rate_t rate;
	} status_t;

	// Interpolation weights that travel with each read
	typedef struct packed {
		logic [2:0] phase;
		logic [2:0] div; // Divisor minus one
	} rd_meta_t;

endpackage

//--- speed_select.sv
`timescale 1ns/1ns

module speed_select import deck_pkg::*; (
	input logic CLOCK_50,
	input logic reset,
	input deck_cmd_t cmd,
	input logic speed_enable,
	output rate_t rate
);

	rate_t rate_next;
	logic step_up;
	logic step_down;

	assign step_up = cmd.faster && !cmd.slower;
	assign step_down = cmd.slower && !cmd.faster;

	always_comb begin
		rate_next = rate;
		if (!speed_enable) begin
			rate_next = RATE_X1;
		end else if (step_up) begin
			if (rate.slow) begin
				if (rate.factor == 3'd1)
					rate_next = RATE_X1; // 1/2 back to x1
				else
					rate_next.factor = rate.factor - 3'd1;
			end else if (rate.factor == 3'(MAX_FACTOR - 1)) begin
				rate_next = RATE_X1; // Wrap from x8
			end else begin
				rate_next.factor = rate.factor + 3'd1;
			end
		end else if (step_down) begin
			if (!rate.slow) begin
				if (rate.factor == 3'd0) begin
					rate_next.slow = 1'b1; // x1 into 1/2
					rate_next.factor = 3'd1;
				end else begin
					rate_next.factor = rate.factor - 3'd1;
				end
			end else if (rate.factor == 3'(MAX_FACTOR - 1)) begin
				rate_next = RATE_X1; // Wrap from 1/8
			end else begin
				rate_next.factor = rate.factor + 3'd1;
			end
		end
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset)
			rate <= RATE_X1;
		else
			rate <= rate_next;
	end

	assert property (@(posedge CLOCK_50) disable iff (reset) !(rate.slow && rate.factor == 3'd0))
		else $error("speed_select: slow rate with factor 0");

endmodule

//--- transport_fsm.sv
`timescale 1ns/1ns

module transport_fsm import deck_pkg::*; (
	input logic CLOCK_50,
	input logic reset,
	input deck_cmd_t cmd,
	input logic end_of_data,
	output deck_state_t state
);

	deck_state_t state_next;
	logic key_play;
	logic key_rec;
	logic key_stop;

	// A key counts only when it is the sole transport key
	assign key_play = cmd.play && !cmd.rec && !cmd.stop;
	assign key_rec = cmd.rec && !cmd.play && !cmd.stop;
	assign key_stop = cmd.stop && !cmd.play && !cmd.rec;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (key_play)
					state_next = PLAY;
				else if (key_rec)
					state_next = REC;
			end
			PLAY: begin
				if (key_stop || end_of_data)
					state_next = IDLE;
				else if (key_play)
					state_next = PLAY_PAUSE;
			end
			REC: begin
				if (key_stop || end_of_data)
					state_next = IDLE; // Stop or memory full
				else if (key_rec)
					state_next = REC_PAUSE;
			end
			PLAY_PAUSE: begin
				if (key_stop)
					state_next = IDLE;
				else if (key_play)
					state_next = PLAY;
			end
			REC_PAUSE: begin
				if (key_stop)
					state_next = IDLE;
				else if (key_rec)
					state_next = REC;
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

	assert property (@(posedge CLOCK_50) disable iff (reset)
		state inside {IDLE, PLAY, REC, REC_PAUSE, PLAY_PAUSE})
		else $error("transport_fsm: illegal state %0d", state);

endmodule

//--- addr_gen.sv
`timescale 1ns/1ns

module addr_gen import deck_pkg::*; #(
	parameter int ADDR_W = 20
) (
	input logic CLOCK_50,
	input logic reset,
	input status_t status,
	input sample_t rec_sample,
	input logic rec_valid,
	output logic rec_ready,
	output logic wr_en,
	output logic [ADDR_W-1:0] wr_addr,
	output sample_t wr_data,
	output logic req_valid,
	input logic req_ready,
	output logic [ADDR_W-1:0] req_addr,
	output rd_meta_t req_meta,
	output logic end_of_data
);

	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rec_len; // One past the last written sample
	logic [ADDR_W:0] rd_ptr;
	logic [ADDR_W:0] rd_step;
	logic [2:0] phase;
	logic [1:0] drain; // Stages left to empty after the last request
	logic last_phase;
	logic all_issued;
	logic playing;
	logic req_fire;

	assign playing = (status.state == PLAY) || (status.state == PLAY_PAUSE);
	assign all_issued = (rd_ptr >= rec_len);
	assign last_phase = (phase >= status.rate.factor);

	assign rec_ready = (status.state == REC) && !end_of_data;
	assign wr_en = rec_valid && rec_ready;
	assign wr_addr = wr_ptr[ADDR_W-1:0];
	assign wr_data = rec_sample;

	// No requests in pause
	assign req_valid = (status.state == PLAY) && !all_issued;
	assign req_fire = req_valid && req_ready;
	assign req_addr = rd_ptr[ADDR_W-1:0];
	assign req_meta.phase = status.rate.slow ? phase : 3'd0;
	assign req_meta.div = status.rate.slow ? status.rate.factor : 3'd0;

	always_comb begin
		if (status.rate.slow)
			rd_step = last_phase ? 1 : 0; // Once per N phases
		else
			rd_step = status.rate.factor + 1'b1; // Skip N-1 samples
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rec_len <= '0;
			rd_ptr <= '0;
			phase <= '0;
			drain <= 2'd2;
			end_of_data <= 1'b0;
		end else if (status.state == IDLE) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			phase <= '0;
			drain <= 2'd2;
			end_of_data <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
				rec_len <= wr_ptr + 1'b1;
				if (&wr_addr)
					end_of_data <= 1'b1; // Memory full
			end
			if (req_fire) begin
				rd_ptr <= rd_ptr + rd_step;
				phase <= (status.rate.slow && !last_phase) ? phase + 3'd1 : 3'd0;
			end
			// Each ready edge moves the last item one stage on
			if (playing && all_issued && drain != 2'd0 && req_ready) begin
				drain <= drain - 2'd1;
				if (drain == 2'd1)
					end_of_data <= 1'b1;
			end
		end
	end

	assert property (@(posedge CLOCK_50) disable iff (reset)
		req_valid |-> ({1'b0, req_addr} < rec_len))
		else $error("addr_gen: read request beyond record length");

endmodule

//--- sample_ram.sv
`timescale 1ns/1ns

module sample_ram import deck_pkg::*; #(
	parameter int ADDR_W = 20
) (
	input logic CLOCK_50,
	input logic reset,
	input logic flush,
	input logic wr_en,
	input logic [ADDR_W-1:0] wr_addr,
	input sample_t wr_data,
	input logic req_valid,
	output logic req_ready,
	input logic [ADDR_W-1:0] req_addr,
	input rd_meta_t req_meta,
	output logic rd_valid,
	input logic rd_ready,
	output sample_t rd_data,
	output rd_meta_t rd_meta
);

	sample_t mem [2**ADDR_W];

	// Read stage only loads when the interpolator can take its contents
	assign req_ready = rd_ready;

	always_ff @(posedge CLOCK_50) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (req_valid && req_ready) begin
			rd_data <= mem[req_addr];
			rd_meta <= req_meta;
		end
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset)
			rd_valid <= 1'b0;
		else if (flush)
			rd_valid <= 1'b0;
		else if (rd_ready)
			rd_valid <= req_valid;
	end

	assert property (@(posedge CLOCK_50) disable iff (reset)
		rd_valid && !rd_ready |=> $stable(rd_data) && $stable(rd_meta))
		else $error("sample_ram: read data changed while stalled");

endmodule

//--- interp.sv
`timescale 1ns/1ns

module interp import deck_pkg::*; (
	input logic CLOCK_50,
	input logic reset,
	input logic flush,
	input logic rd_valid,
	output logic rd_ready,
	input sample_t rd_data,
	input rd_meta_t rd_meta,
	output logic play_valid,
	input logic play_ready,
	output sample_t play_sample
);

	sample_t prev; // Sample of the previous address
	logic signed [4:0] w_prev;
	logic signed [4:0] w_cur;
	logic signed [SAMPLE_W+3:0] sum;
	logic signed [SAMPLE_W+3:0] quot;
	logic take;

	assign rd_ready = !play_valid || play_ready;
	assign take = rd_valid && rd_ready;

	// (N-p)*prev + p*cur, then divide by N
	always_comb begin
		w_cur = $signed({2'b00, rd_meta.phase});
		w_prev = $signed({2'b00, rd_meta.div}) + 5'sd1 - w_cur;
		sum = w_prev * prev + w_cur * rd_data;
		case (rd_meta.div)
			3'd0: quot = rd_data; // x1 and fast rates
			3'd1: quot = sum / 2;
			3'd2: quot = sum / 3;
			3'd3: quot = sum / 4;
			3'd4: quot = sum / 5;
			3'd5: quot = sum / 6;
			3'd6: quot = sum / 7;
			3'd7: quot = sum / 8;
		endcase
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			play_valid <= 1'b0;
			prev <= '0;
		end else if (flush) begin
			play_valid <= 1'b0;
			prev <= '0; // First address weighs against silence
		end else begin
			if (rd_ready)
				play_valid <= rd_valid;
			if (take && rd_meta.phase >= rd_meta.div)
				prev <= rd_data; // Last phase of this address
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (take)
			play_sample <= quot[SAMPLE_W-1:0];
	end

endmodule

//--- tape_deck.sv
`timescale 1ns/1ns

module tape_deck import deck_pkg::*; #(
	parameter int ADDR_W = 20
) (
	input logic CLOCK_50,
	input logic reset,
	input deck_cmd_t cmd,
	input logic speed_enable,
	input sample_t rec_sample,
	input logic rec_valid,
	output logic rec_ready,
	output sample_t play_sample,
	output logic play_valid,
	input logic play_ready,
	output status_t status
);

	deck_state_t state;
	rate_t rate;
	logic end_of_data;
	logic flush;
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	sample_t wr_data;
	logic req_valid;
	logic req_ready;
	logic [ADDR_W-1:0] req_addr;
	rd_meta_t req_meta;
	logic rd_valid;
	logic rd_ready;
	sample_t rd_data;
	rd_meta_t rd_meta;

	assign status = '{state: state, rate: rate};
	assign flush = (state == IDLE); // Empties the read pipeline

	speed_select u_speed_select (
		.*
	);

	transport_fsm u_transport_fsm (
		.*
	);

	addr_gen #(
		.ADDR_W(ADDR_W)
	) u_addr_gen (
		.*
	);

	sample_ram #(
		.ADDR_W(ADDR_W)
	) u_sample_ram (
		.*
	);

	interp u_interp (
		.*
	);

endmodule

//--- tb_tape_deck_ref.svh
// Walk position +k is x(k+1) and -k is 1/(k+1)
function automatic rate_t rate_of_pos(input int pos);
	rate_t r;
	r.slow = (pos < 0);
	r.factor = 3'(pos < 0 ? -pos : pos);
	return r;
endfunction

function automatic int step_pos(input int pos, input bit up);
	if (up)
		return (pos == MAX_FACTOR - 1) ? 0 : pos + 1; // x8 wraps to x1
	return (pos == 1 - MAX_FACTOR) ? 0 : pos - 1; // 1/8 wraps to x1
endfunction

function automatic int expected_count(input int len, input rate_t r);
	int n;
	n = int'(r.factor) + 1;
	return r.slow ? len * n : (len + n - 1) / n;
endfunction

// Output j of a recording played at rate r
function automatic sample_t ref_sample(input sample_t samples[$], input rate_t r, input int j);
	int n;
	int prev_s;
	int cur_s;
	n = int'(r.factor) + 1;
	if (!r.slow)
		return samples[j * n];
	prev_s = (j / n == 0) ? 0 : int'(samples[j / n - 1]); // Silence before the first sample
	cur_s = int'(samples[j / n]);
	return sample_t'(((n - j % n) * prev_s + (j % n) * cur_s) / n);
endfunction

task automatic check_sample(input sample_t got, input sample_t want);
	checks++;
	if (got !== want) begin
		errors++;
		$display("[ERROR] %0t: play sample %0d, expected %0d", $time, got, want);
	end
endtask

task automatic check_state(input deck_state_t got, input deck_state_t want);
	checks++;
	if (got !== want) begin
		errors++;
		$display("[ERROR] %0t: state %s, expected %s", $time, got.name(), want.name());
	end
endtask

task automatic check_rate(input rate_t got, input rate_t want);
	checks++;
	if (got !== want) begin
		errors++;
		$display("[ERROR] %0t: rate slow=%0b factor=%0d, expected slow=%0b factor=%0d",
			$time, got.slow, got.factor, want.slow, want.factor);
	end
endtask

//--- tb_tape_deck.sv
`timescale 1ns/1ns

module tb_tape_deck import deck_pkg::*; ();

	localparam deck_cmd_t CMD_PLAY = 5'b10000;
	localparam deck_cmd_t CMD_REC = 5'b01000;
	localparam deck_cmd_t CMD_STOP = 5'b00100;
	localparam deck_cmd_t CMD_FASTER = 5'b00010;
	localparam deck_cmd_t CMD_SLOWER = 5'b00001;
	localparam int TOTAL_SAMPLES = 20 + 12 + 12 + 70;
	// Up to 8 phases per sample and random ready about halves the rate
	localparam int CYCLE_LIMIT = TOTAL_SAMPLES * MAX_FACTOR * 2 + 1000;

	logic CLOCK_50;
	logic reset;
	deck_cmd_t cmd;
	logic speed_enable;
	sample_t rec_sample;
	logic rec_valid;
	logic rec_ready;
	sample_t play_sample;
	logic play_valid;
	logic play_ready;
	status_t status;

	sample_t stored[$]; // Samples the DUT accepted
	sample_t exp_q[$];
	int rate_pos = 0;
	int errors = 0;
	int errors_before = 0;
	int checks = 0;
	int got_count = 0;
	int cycles = 0;
	logic quiet;

	`include "tb_tape_deck_ref.svh"

	tape_deck #(
		.ADDR_W(6)
	) dut (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.cmd(cmd),
		.speed_enable(speed_enable),
		.rec_sample(rec_sample),
		.rec_valid(rec_valid),
		.rec_ready(rec_ready),
		.play_sample(play_sample),
		.play_valid(play_valid),
		.play_ready(play_ready),
		.status(status)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	task automatic send_cmd(input deck_cmd_t c);
		cmd <= c;
		@(posedge CLOCK_50);
		cmd <= '0;
	endtask

	task automatic press_rate(input bit up);
		rate_pos = step_pos(rate_pos, up);
		send_cmd(up ? CMD_FASTER : CMD_SLOWER);
		@(posedge CLOCK_50);
		check_rate(status.rate, rate_of_pos(rate_pos));
	endtask

	task automatic select_rate(input int pos);
		speed_enable <= 1'b0; // Falls back to x1
		@(posedge CLOCK_50);
		speed_enable <= 1'b1;
		rate_pos = 0;
		while (rate_pos != pos)
			press_rate(pos > 0);
	endtask

	task automatic record_samples(input int n, input int pause_at);
		sample_t s;
		bit full;
		full = 1'b0;
		stored.delete();
		send_cmd(CMD_REC);
		while (stored.size() < n && !full) begin
			if (stored.size() == pause_at) begin
				rec_valid <= 1'b0;
				send_cmd(CMD_REC);
				repeat (4) @(posedge CLOCK_50);
				check_state(status.state, REC_PAUSE);
				if (rec_ready) begin
					errors++;
					$display("rec_ready stayed high during record pause at %0t", $time);
				end
				send_cmd(CMD_REC);
			end
			s = sample_t'($urandom);
			rec_valid <= 1'b1;
			rec_sample <= s;
			do
				@(posedge CLOCK_50);
			while (!rec_ready && status.state != IDLE);
			if (rec_ready)
				stored.push_back(s);
			else
				full = 1'b1; // Memory full and the deck went idle
		end
		rec_valid <= 1'b0;
		send_cmd(CMD_STOP);
		@(posedge CLOCK_50);
		check_state(status.state, IDLE);
	endtask

	task automatic play_and_check(input bit random_ready, input bit do_pause);
		rate_t r;
		int n_exp;
		int start;
		bit paused;
		r = rate_of_pos(rate_pos);
		n_exp = expected_count(stored.size(), r);
		for (int j = 0; j < n_exp; j++)
			exp_q.push_back(ref_sample(stored, r, j));
		start = got_count;
		paused = 1'b0;
		send_cmd(CMD_PLAY);
		@(posedge CLOCK_50);
		while (status.state != IDLE) begin
			if (do_pause && !paused && got_count - start >= n_exp / 2) begin
				paused = 1'b1;
				play_ready <= 1'b1;
				send_cmd(CMD_PLAY);
				repeat (4) @(posedge CLOCK_50); // In-flight items drain
				check_state(status.state, PLAY_PAUSE);
				quiet <= 1'b1;
				repeat (8) @(posedge CLOCK_50);
				quiet <= 1'b0;
				send_cmd(CMD_PLAY);
			end
			play_ready <= random_ready ? 1'($urandom) : 1'b1;
			@(posedge CLOCK_50);
		end
		play_ready <= 1'b1;
		repeat (4) @(posedge CLOCK_50);
		if (exp_q.size() != 0) begin
			errors++;
			$display("Playback ended with %0d samples still missing", exp_q.size());
		end
		exp_q.delete();
	endtask

	task automatic report_test(input int num, input string name);
		if (errors == errors_before)
			$display("Test %0d, %s: ok", num, name);
		else
			$display("Test %0d, %s: %0d errors", num, name, errors - errors_before);
		errors_before = errors;
	endtask

	// Compares every accepted play sample in order
	always @(posedge CLOCK_50) begin
		if (!reset && play_valid && play_ready) begin
			got_count <= got_count + 1;
			if (exp_q.size() == 0) begin
				errors++;
				$display("Unexpected play sample %0d at time %0t", play_sample, $time);
			end else begin
				check_sample(play_sample, exp_q.pop_front());
			end
		end
		if (quiet && play_valid) begin
			errors++;
			$display("play_valid high while paused at time %0t", $time);
		end
	end

	always @(posedge CLOCK_50) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'he6bd_655a));
		reset = 1'b1;
		cmd = '0;
		speed_enable = 1'b0;
		rec_sample = '0;
		rec_valid = 1'b0;
		play_ready = 1'b1;
		quiet = 1'b0;
		repeat (3) @(posedge CLOCK_50);
		reset <= 1'b0;
		@(posedge CLOCK_50);
		check_state(status.state, IDLE);
		check_rate(status.rate, rate_of_pos(0));

		record_samples(20, -1);
		play_and_check(1'b0, 1'b0);
		report_test(1, "record then play at x1");

		speed_enable <= 1'b1;
		@(posedge CLOCK_50);
		repeat (8) press_rate(1'b1);
		repeat (8) press_rate(1'b0);
		repeat (12) press_rate(1'($urandom));
		speed_enable <= 1'b0;
		rate_pos = 0;
		repeat (2) begin
			send_cmd(CMD_FASTER); // Held at x1 while disabled
			@(posedge CLOCK_50);
			check_rate(status.rate, rate_of_pos(0));
		end
		report_test(2, "rate walk");

		select_rate(2);
		play_and_check(1'b0, 1'b0);
		report_test(3, "fast playback at x3");

		record_samples(12, -1);
		select_rate(-3);
		play_and_check(1'b0, 1'b0);
		report_test(4, "slow playback at 1/4");

		record_samples(12, 5);
		select_rate(-3);
		play_and_check(1'b1, 1'b1);
		report_test(5, "back-pressure and pause");

		record_samples(70, -1);
		if (stored.size() != 64) begin
			errors++;
			$display("Recording kept %0d samples instead of 64", stored.size());
		end
		if (rec_ready) begin
			errors++;
			$display("rec_ready still high after the memory filled");
		end
		select_rate(0);
		play_and_check(1'b0, 1'b0);
		report_test(6, "record full");

		$display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- tape_deck.f
+incdir+.
deck_pkg.sv
speed_select.sv
transport_fsm.sv
addr_gen.sv
sample_ram.sv
interp.sv
tape_deck.sv
tb_tape_deck.sv

//--- run.sh
#!/bin/sh
# Builds and runs the tape deck testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tape_deck.f \
	--top-module tb_tape_deck -o tb_tape_deck
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_tape_deck > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
exit 0
